/* tb.f */
+incdir+include
verilog/spi_pkg.sv
verilog/spi_master.sv
verilog/spi_arbiter.sv
verilog/spi_poller.sv
verilog/spi_subsystem.sv
dv/spi_device_model.sv
dv/tb_spi_subsystem.sv

/* Bender.yml */
package:
  name: spi_subsystem

sources:
  - include_dirs:
      - include
    files:
      - verilog/spi_pkg.sv
      - verilog/spi_master.sv
      - verilog/spi_arbiter.sv
      - verilog/spi_poller.sv
      - verilog/spi_subsystem.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/spi_device_model.sv
      - dv/tb_spi_subsystem.sv

/* dv/tb_spi_subsystem.sv */
`timescale 1ns/1ns
`default_nettype none

`include "spi_macros.svh"

module tb_spi_subsystem;

  localparam int POLL_WINDOW = 2 * (`SPI_POLL_INTERVAL + 250); // long enough for one full poll

  logic                    clk;
  logic                    rst_n;
  spi_pkg::spi_cmd_t       host_cmd;
  logic                    host_cmd_vld;
  logic                    poll_en;
  spi_pkg::spi_addr_t      poll_addr;
  wire                     miso;
  wire                     host_cmd_rdy;
  wire                     host_read_vld;
  wire spi_pkg::spi_data_t host_read_data;
  wire spi_pkg::spi_data_t status_value;
  wire                     status_valid;
  wire                     status_changed;
  wire                     sclk;
  wire                     cs_n;
  wire                     mosi;

  logic [31:0]        lfsr;
  spi_pkg::spi_data_t exp_regs [8];
  int                 pass_cnt;
  int                 fail_cnt;
  int                 rd_vld_cnt;
  int                 changed_cnt;

  spi_subsystem dut_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .host_cmd       (host_cmd),
    .host_cmd_vld   (host_cmd_vld),
    .poll_en        (poll_en),
    .poll_addr      (poll_addr),
    .miso           (miso),
    .host_cmd_rdy   (host_cmd_rdy),
    .host_read_vld  (host_read_vld),
    .host_read_data (host_read_data),
    .status_value   (status_value),
    .status_valid   (status_valid),
    .status_changed (status_changed),
    .sclk           (sclk),
    .cs_n           (cs_n),
    .mosi           (mosi)
  );

  spi_device_model device_i (
    .sclk (sclk),
    .cs_n (cs_n),
    .mosi (mosi),
    .miso (miso)
  );

  initial
    clk = 1'b0;

  always #10 clk = ~clk;

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic check_data(input string name, input spi_pkg::spi_data_t exp_v,
                            input spi_pkg::spi_data_t act_v);
    if (exp_v !== act_v)
    begin
      $display("FAILED %s: expected %h, actual %h", name, exp_v, act_v);
      fail_cnt++;
    end
    else
      pass_cnt++;
  endtask

  task automatic check_flag(input string name, input logic exp_v, input logic act_v);
    if (exp_v !== act_v)
    begin
      $display("FAILED %s: expected %b, actual %b", name, exp_v, act_v);
      fail_cnt++;
    end
    else
      pass_cnt++;
  endtask

  task automatic check_count(input string name, input int exp_v, input int act_v);
    if (exp_v != act_v)
    begin
      $display("FAILED %s: expected %0d, actual %0d", name, exp_v, act_v);
      fail_cnt++;
    end
    else
      pass_cnt++;
  endtask

  task automatic report_test(input string name);
    $display("test %-20s done, %0d failed checks so far", name, fail_cnt);
  endtask

  // holds vld until the arbiter grants the host, returns on the next falling edge
  task automatic send_cmd(input spi_pkg::spi_op_e op, input spi_pkg::spi_addr_t addr,
                          input spi_pkg::spi_data_t data, output int stalled);
    stalled = 0;
    @(negedge clk);
    host_cmd     = {op, addr, data};
    host_cmd_vld = 1'b1;
    @(posedge clk);
    while (!host_cmd_rdy)
    begin
      stalled++;
      @(posedge clk);
    end
    if (op == spi_pkg::op_write)
      exp_regs[addr] = data;
    @(negedge clk);
    host_cmd_vld = 1'b0;
  endtask

  task automatic read_and_check(input spi_pkg::spi_addr_t addr, input string name,
                                output int stalled);
    send_cmd(spi_pkg::op_read, addr, '0, stalled);
    do
    begin
      @(posedge clk);
    end
    while (!host_read_vld);
    check_data(name, exp_regs[addr], host_read_data);
  endtask

  always @(posedge clk)
  begin
    if (host_read_vld)
      rd_vld_cnt <= rd_vld_cnt + 1;
    if (status_changed)
      changed_cnt <= changed_cnt + 1;
  end

  initial
  begin
    spi_pkg::spi_addr_t pa;
    spi_pkg::spi_data_t v;
    int                 stalled;
    int                 w0;
    int                 r0;
    int                 c0;
    int                 n_reads;
    int                 n_writes;
    int                 n;
    lfsr        = 32'hc786d0ff;
    pass_cnt    = 0;
    fail_cnt    = 0;
    rd_vld_cnt  = 0;
    changed_cnt = 0;
    for (int i = 0; i < 8; i++)
      exp_regs[i] = '0;
    rst_n        = 1'b0;
    host_cmd     = '0;
    host_cmd_vld = 1'b0;
    poll_en      = 1'b0;
    poll_addr    = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    check_flag("reset host_cmd_rdy", 1'b1, host_cmd_rdy);
    check_flag("reset cs_n", 1'b1, cs_n);
    check_flag("reset sclk", 1'b0, sclk);
    check_flag("reset mosi", 1'b0, mosi);
    check_flag("reset host_read_vld", 1'b0, host_read_vld);
    check_flag("reset status_valid", 1'b0, status_valid);
    check_flag("reset status_changed", 1'b0, status_changed);
    report_test("reset");

    // six writes cannot cover all eight registers, so some reads see the reset value
    repeat (6)
    begin
      pa = spi_pkg::spi_addr_t'(take_bits(3));
      v  = spi_pkg::spi_data_t'(take_bits(8));
      send_cmd(spi_pkg::op_write, pa, v, stalled);
    end
    for (int i = 0; i < 8; i++)
      read_and_check(spi_pkg::spi_addr_t'(i), "write then read", stalled);
    report_test("write_read");

    @(negedge clk);
    w0 = device_i.wr_cnt;
    r0 = rd_vld_cnt;
    pa = spi_pkg::spi_addr_t'(take_bits(3));
    v  = spi_pkg::spi_data_t'(take_bits(8));
    send_cmd(spi_pkg::op_write, pa, v, stalled);
    read_and_check(pa, "read behind busy write", stalled);
    @(negedge clk);
    check_flag("read held across busy", 1'b1, stalled > 0);
    check_count("device writes", w0 + 1, device_i.wr_cnt);
    check_count("host read_vld pulses", r0 + 1, rd_vld_cnt);
    report_test("back_pressure");

    pa        = spi_pkg::spi_addr_t'(take_bits(3));
    poll_addr = pa;
    poll_en   = 1'b1;
    n = 0;
    while (!status_valid && n < POLL_WINDOW)
    begin
      @(negedge clk);
      n++;
    end
    check_flag("status_valid rises", 1'b1, status_valid);
    check_data("first poll value", exp_regs[pa], status_value);
    report_test("poll_first");

    c0 = changed_cnt;
    v  = spi_pkg::spi_data_t'(take_bits(8));
    if (v == exp_regs[pa])
      v = ~v;
    send_cmd(spi_pkg::op_write, pa, v, stalled);
    n = 0;
    while (changed_cnt == c0 && n < POLL_WINDOW)
    begin
      @(negedge clk);
      n++;
    end
    check_count("status_changed on new value", c0 + 1, changed_cnt);
    check_data("status_value after change", v, status_value);
    c0 = changed_cnt;
    send_cmd(spi_pkg::op_write, pa, v, stalled);
    repeat (POLL_WINDOW) @(negedge clk);
    check_count("no pulse on same value", c0, changed_cnt);
    check_data("status_value holds", v, status_value);
    report_test("poll_change");

    // back to back host traffic keeps the host requesting whenever the poller wakes up
    w0       = device_i.wr_cnt;
    r0       = rd_vld_cnt;
    n_reads  = 0;
    n_writes = 0;
    repeat (30)
    begin
      pa = spi_pkg::spi_addr_t'(take_bits(3));
      v  = spi_pkg::spi_data_t'(take_bits(8));
      if (take_bits(1) != 0)
      begin
        send_cmd(spi_pkg::op_write, pa, v, stalled);
        n_writes++;
      end
      else
      begin
        read_and_check(pa, "shared bus read", stalled);
        n_reads++;
      end
    end
    // the poller keeps reading during this wait and none of it may reach the host port
    repeat (POLL_WINDOW) @(negedge clk);
    check_count("device writes with poller", w0 + n_writes, device_i.wr_cnt);
    check_count("host read_vld with poller", r0 + n_reads, rd_vld_cnt);
    check_data("poll value after shared bus", exp_regs[poll_addr], status_value);
    report_test("shared_bus");

    $display("checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

  initial
  begin
    #(200 * (`SPI_POLL_INTERVAL + 250) * 20);
    $display("run timed out before all tests finished");
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

/* dv/spi_device_model.sv */
`timescale 1ns/1ns
`default_nettype none

module spi_device_model (
  input  wire  sclk,
  input  wire  cs_n,
  input  wire  mosi,
  output logic miso
);

  logic [7:0]  regs [8];
  logic [11:0] rx_word;
  logic        hdr_op;
  logic [2:0]  hdr_addr;
  int          rx_bits;
  int          out_idx;
  int          wr_cnt; // writes committed to the register array

  initial
  begin
    for (int i = 0; i < 8; i++)
      regs[i] = '0; // registers come up cleared
    rx_bits = 0;
    wr_cnt  = 0;
    hdr_op  = 1'b1;
    miso    = 1'b0;
  end

  always @(negedge cs_n)
  begin
    rx_bits = 0;
    rx_word = '0;
    hdr_op  = 1'b1; // nothing goes out on miso until a read header is seen
  end

  always @(posedge cs_n)
    miso = 1'b0;

  always @(posedge sclk)
  begin
    if (!cs_n)
    begin
      rx_word = {rx_word[10:0], mosi};
      rx_bits = rx_bits + 1;
      if (rx_bits == 4)
      begin
        hdr_op   = rx_word[3];
        hdr_addr = rx_word[2:0];
      end
      if (rx_bits == 12 && rx_word[11])
      begin
        regs[rx_word[10:8]] = rx_word[7:0];
        wr_cnt = wr_cnt + 1;
      end
    end
  end

  // read data moves on each falling edge, the first one closes the header
  always @(negedge sclk)
  begin
    if (!cs_n && !hdr_op && rx_bits >= 4)
    begin
      out_idx = 11 - rx_bits;
      miso    = (out_idx >= 0) ? regs[hdr_addr][out_idx] : 1'b0;
    end
  end

endmodule

`default_nettype wire

/* verilog/spi_subsystem.sv */
`timescale 1ns/1ns
`default_nettype none

module spi_subsystem (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire spi_pkg::spi_cmd_t  host_cmd,
  input  wire                     host_cmd_vld,
  input  wire                     poll_en,
  input  wire spi_pkg::spi_addr_t poll_addr,
  input  wire                     miso,
  output wire                     host_cmd_rdy,
  output wire                     host_read_vld,
  output wire spi_pkg::spi_data_t host_read_data,
  output wire spi_pkg::spi_data_t status_value,
  output wire                     status_valid,
  output wire                     status_changed,
  output wire                     sclk,
  output wire                     cs_n,
  output wire                     mosi
);

  wire spi_pkg::spi_cmd_t  poll_cmd;
  wire                     poll_cmd_vld;
  wire                     poll_cmd_rdy;
  wire                     poll_read_vld;
  wire spi_pkg::spi_data_t poll_read_data;

  // arbiter to master
  wire spi_pkg::spi_cmd_t  m_cmd;
  wire                     m_cmd_vld;
  wire                     m_cmd_rdy;
  wire                     m_read_vld;
  wire spi_pkg::spi_data_t m_read_data;

  spi_poller poller_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .poll_en        (poll_en),
    .poll_addr      (poll_addr),
    .cmd_rdy        (poll_cmd_rdy),
    .read_vld       (poll_read_vld),
    .read_data      (poll_read_data),
    .cmd            (poll_cmd),
    .cmd_vld        (poll_cmd_vld),
    .status_value   (status_value),
    .status_valid   (status_valid),
    .status_changed (status_changed)
  );

  spi_arbiter arbiter_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .host_cmd       (host_cmd),
    .host_cmd_vld   (host_cmd_vld),
    .poll_cmd       (poll_cmd),
    .poll_cmd_vld   (poll_cmd_vld),
    .cmd_rdy        (m_cmd_rdy),
    .read_vld       (m_read_vld),
    .read_data      (m_read_data),
    .host_cmd_rdy   (host_cmd_rdy),
    .host_read_vld  (host_read_vld),
    .host_read_data (host_read_data),
    .poll_cmd_rdy   (poll_cmd_rdy),
    .poll_read_vld  (poll_read_vld),
    .poll_read_data (poll_read_data),
    .cmd            (m_cmd),
    .cmd_vld        (m_cmd_vld)
  );

  spi_master master_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (m_cmd),
    .cmd_vld   (m_cmd_vld),
    .miso      (miso),
    .cmd_rdy   (m_cmd_rdy),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .read_vld  (m_read_vld),
    .read_data (m_read_data)
  );

endmodule

`default_nettype wire

/* verilog/spi_poller.sv */
`timescale 1ns/1ns
`default_nettype none

`include "spi_macros.svh"

module spi_poller (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     poll_en,
  input  wire spi_pkg::spi_addr_t poll_addr,
  input  wire                     cmd_rdy,
  input  wire                     read_vld,
  input  wire spi_pkg::spi_data_t read_data,
  output spi_pkg::spi_cmd_t       cmd,
  output logic                    cmd_vld,
  output spi_pkg::spi_data_t      status_value,
  output logic                    status_valid,
  output logic                    status_changed
);

  localparam int CNT_W = $clog2(`SPI_POLL_INTERVAL);

  spi_pkg::poll_state_e state;
  spi_pkg::spi_addr_t   req_addr;
  logic [CNT_W-1:0]     wait_cnt;
  logic                 interval_done;
  logic                 launch;
  logic                 read_done;

  assign interval_done = (wait_cnt == CNT_W'(`SPI_POLL_INTERVAL - 1));
  assign launch        = (state == spi_pkg::ps_wait) && interval_done && poll_en;
  assign read_done     = (state == spi_pkg::ps_busy) && read_vld;

  // the address is latched at launch so cmd stays stable while vld waits
  assign cmd     = {spi_pkg::op_read, req_addr, {`SPI_DATA_WIDTH{1'b0}}};
  assign cmd_vld = (state == spi_pkg::ps_request);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state          <= spi_pkg::ps_wait;
      wait_cnt       <= '0;
      status_valid   <= 1'b0;
      status_changed <= 1'b0;
    end
    else
    begin
      status_changed <= 1'b0;
      case (state)
        spi_pkg::ps_wait:
        begin
          if (!interval_done)
            wait_cnt <= wait_cnt + 1'b1; // saturates, then waits for poll_en
          else if (launch)
            state <= spi_pkg::ps_request;
        end
        spi_pkg::ps_request:
        begin
          if (cmd_rdy)
            state <= spi_pkg::ps_busy;
        end
        spi_pkg::ps_busy:
        begin
          if (read_done)
          begin
            status_valid   <= 1'b1;
            status_changed <= status_valid && (read_data != status_value);
            wait_cnt       <= '0;
            state          <= spi_pkg::ps_wait;
          end
        end
        default:
          state <= spi_pkg::ps_wait;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (launch)
      req_addr <= poll_addr;
    if (read_done)
      status_value <= read_data;
  end

endmodule

`default_nettype wire

/* verilog/spi_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module spi_arbiter (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire spi_pkg::spi_cmd_t  host_cmd,
  input  wire                     host_cmd_vld,
  input  wire spi_pkg::spi_cmd_t  poll_cmd,
  input  wire                     poll_cmd_vld,
  input  wire                     cmd_rdy,
  input  wire                     read_vld,
  input  wire spi_pkg::spi_data_t read_data,
  output logic                    host_cmd_rdy,
  output logic                    host_read_vld,
  output spi_pkg::spi_data_t      host_read_data,
  output logic                    poll_cmd_rdy,
  output logic                    poll_read_vld,
  output spi_pkg::spi_data_t      poll_read_data,
  output spi_pkg::spi_cmd_t       cmd,
  output logic                    cmd_vld
);

  spi_pkg::requester_e owner; // winner of the last accepted command
  spi_pkg::requester_e sel;

  always_comb
  begin
    sel = owner; // hold the grant while the master is busy
    if (cmd_rdy)
    begin
      if (host_cmd_vld && poll_cmd_vld)
        sel = (owner == spi_pkg::req_host) ? spi_pkg::req_poll : spi_pkg::req_host;
      else if (poll_cmd_vld)
        sel = spi_pkg::req_poll;
      else
        sel = spi_pkg::req_host;
    end
  end

  assign cmd          = (sel == spi_pkg::req_host) ? host_cmd : poll_cmd;
  assign cmd_vld      = (sel == spi_pkg::req_host) ? host_cmd_vld : poll_cmd_vld;
  assign host_cmd_rdy = cmd_rdy && (sel == spi_pkg::req_host);
  assign poll_cmd_rdy = cmd_rdy && (sel == spi_pkg::req_poll);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      owner <= spi_pkg::req_poll; // host wins the first tie
    else if (cmd_vld && cmd_rdy)
      owner <= sel;
  end

  // read results go back to whoever launched the transfer
  assign host_read_vld  = read_vld && (owner == spi_pkg::req_host);
  assign poll_read_vld  = read_vld && (owner == spi_pkg::req_poll);
  assign host_read_data = read_data;
  assign poll_read_data = read_data;

  // a read result arrives while owner still names the requester that launched it
  owner_held: assert property (@(posedge clk) disable iff (!rst_n)
    read_vld |-> !cmd_rdy && $stable(owner));

endmodule

`default_nettype wire

/* verilog/spi_master.sv */
`timescale 1ns/1ns
`default_nettype none

`include "spi_macros.svh"

module spi_master (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire spi_pkg::spi_cmd_t  cmd,
  input  wire                     cmd_vld,
  input  wire                     miso,
  output logic                    cmd_rdy,
  output logic                    sclk,
  output logic                    cs_n,
  output logic                    mosi,
  output logic                    read_vld,
  output spi_pkg::spi_data_t      read_data
);

  localparam int DIV_W = $clog2(2 * `SPI_HALF_PERIOD);
  localparam int TA_W  = $clog2(`SPI_TURNAROUND);
  localparam int BIT_W = $clog2(`SPI_CMD_WIDTH);

  spi_pkg::spi_state_e state;
  spi_pkg::spi_op_e    cur_op;
  spi_pkg::spi_cmd_t   tx_shift;
  spi_pkg::spi_data_t  rx_shift;
  logic [DIV_W-1:0]    div_cnt;
  logic [BIT_W-1:0]    bit_cnt;
  logic [TA_W-1:0]     ta_cnt;
  logic [BIT_W-1:0]    last_out;
  logic                accept;
  logic                rise;
  logic                bit_end;
  logic                in_done;

  assign cmd_rdy  = (state == spi_pkg::st_idle);
  assign accept   = cmd_vld && cmd_rdy;
  assign rise     = (div_cnt == DIV_W'(`SPI_HALF_PERIOD - 1));     // sclk goes high next cycle
  assign bit_end  = (div_cnt == DIV_W'(2 * `SPI_HALF_PERIOD - 1)); // sclk falls, next bit
  assign last_out = (cur_op == spi_pkg::op_write) ? BIT_W'(`SPI_CMD_WIDTH - 1)
                                                  : BIT_W'(`SPI_HDR_BITS - 1);
  assign in_done  = (state == spi_pkg::st_shift_in) && bit_end
                    && (bit_cnt == BIT_W'(`SPI_DATA_WIDTH - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= spi_pkg::st_idle;
      cur_op   <= spi_pkg::op_read;
      div_cnt  <= '0;
      bit_cnt  <= '0;
      ta_cnt   <= '0;
      sclk     <= 1'b0;
      cs_n     <= 1'b1;
      mosi     <= 1'b0;
      read_vld <= 1'b0;
    end
    else
    begin
      read_vld <= 1'b0;
      case (state)
        spi_pkg::st_idle:
        begin
          if (accept)
          begin
            state   <= spi_pkg::st_load;
            cs_n    <= 1'b0;
            mosi    <= cmd[`SPI_CMD_WIDTH-1]; // first bit valid before the first rising edge
            div_cnt <= '0;
            bit_cnt <= '0;
          end
        end
        spi_pkg::st_load:
        begin
          // this cycle also counts as the first low cycle of bit 0
          cur_op  <= spi_pkg::spi_op_e'(tx_shift[`SPI_CMD_WIDTH-1]);
          div_cnt <= div_cnt + 1'b1;
          state   <= spi_pkg::st_shift_out;
        end
        spi_pkg::st_shift_out:
        begin
          if (rise)
            sclk <= 1'b1;
          if (bit_end)
          begin
            sclk    <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            mosi    <= tx_shift[`SPI_CMD_WIDTH-2];
            if (bit_cnt == last_out)
            begin
              mosi <= 1'b0;
              if (cur_op == spi_pkg::op_write)
              begin
                cs_n  <= 1'b1;
                state <= spi_pkg::st_finish;
              end
              else
              begin
                ta_cnt <= '0;
                state  <= spi_pkg::st_turnaround;
              end
            end
          end
          else
          begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        spi_pkg::st_turnaround:
        begin
          ta_cnt <= ta_cnt + 1'b1; // cs_n stays low, sclk parked low
          if (ta_cnt == TA_W'(`SPI_TURNAROUND - 1))
          begin
            div_cnt <= '0;
            bit_cnt <= '0;
            state   <= spi_pkg::st_shift_in;
          end
        end
        spi_pkg::st_shift_in:
        begin
          if (rise)
            sclk <= 1'b1;
          if (bit_end)
          begin
            sclk    <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            if (in_done)
            begin
              cs_n     <= 1'b1;
              read_vld <= 1'b1;
              state    <= spi_pkg::st_finish;
            end
          end
          else
          begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        spi_pkg::st_finish:
          state <= spi_pkg::st_idle;
        default:
          state <= spi_pkg::st_idle;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      tx_shift <= cmd;
    else if (state == spi_pkg::st_shift_out && bit_end)
      tx_shift <= tx_shift << 1;
    // miso is sampled on the same edge that raises sclk
    if (state == spi_pkg::st_shift_in && rise)
      rx_shift <= {rx_shift[`SPI_DATA_WIDTH-2:0], miso};
    if (in_done)
      read_data <= rx_shift;
  end

  idle_cs_high: assert property (@(posedge clk) disable iff (!rst_n)
    (state == spi_pkg::st_idle) |-> cs_n);

  // a new command is only taken once chip select has been high for a full cycle
  accept_cs_gap: assert property (@(posedge clk) disable iff (!rst_n)
    accept |-> cs_n && $past(cs_n));

endmodule

`default_nettype wire

/* verilog/spi_pkg.sv */
`default_nettype none

`include "spi_macros.svh"

package spi_pkg;

  typedef logic [`SPI_CMD_WIDTH-1:0]  spi_cmd_t;
  typedef logic [`SPI_DATA_WIDTH-1:0] spi_data_t;
  typedef logic [`SPI_ADDR_WIDTH-1:0] spi_addr_t;

  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } spi_op_e;

  typedef enum logic [3:0] {
    st_idle,
    st_load,
    st_shift_out,
    st_turnaround,
    st_shift_in,
    st_finish
  } spi_state_e;

  typedef enum logic {
    req_host,
    req_poll
  } requester_e;

  typedef enum logic [1:0] {
    ps_wait,
    ps_request,
    ps_busy
  } poll_state_e;

endpackage

`default_nettype wire

/* include/spi_macros.svh */
`ifndef SPI_MACROS_SVH
`define SPI_MACROS_SVH

// command layout is op, addr, data from msb down
`define SPI_CMD_WIDTH     12
`define SPI_DATA_WIDTH    8
`define SPI_ADDR_WIDTH    3

// bits shifted out ahead of the turnaround on a read
`define SPI_HDR_BITS      (`SPI_CMD_WIDTH - `SPI_DATA_WIDTH)

`define SPI_HALF_PERIOD   4    // clk cycles per sclk half period
`define SPI_TURNAROUND    16   // clk cycles between read address and read data
`define SPI_POLL_INTERVAL 400  // clk cycles between status polls

`endif
